/* tb.f */
+incdir+.
rename_pkg.sv
free_list.sv
spec_alias_table.sv
arch_alias_table.sv
rename_top.sv
tb_rename.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the rename testbench with Verilator and runs it.
# Exit status is 0 only when the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_rename -f tb.f -o sim_rename
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_rename 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "TEST RESULT: PASS"; then
  exit 0
fi
exit 1

/* tb_rename.sv */
// Random rename/commit testbench with in-order ROB model; value checks are PREG_NUM bits wide
`timescale 1ns/1ps
`include "rename_defs.svh"

module tb_rename;

  localparam int unsigned SEED       = 6;
  localparam int          NUM_ITER   = 1200;  // Random cycles
  localparam int          WAIT_LIMIT = 200;   // Cycles per wait loop

  typedef logic [`PREG_NUM-1:0] wide_t;       // Common width for value checks

  // ============================================================
  // DUT signals
  // ============================================================

  logic                              clk;
  logic                              rst_n;
  logic [`RN_WIDTH-1:0]              rn_valid;
  logic [`RN_WIDTH-1:0]              rn_dst_en;
  rename_pkg::areg_t [`RN_WIDTH-1:0] rn_dst;
  rename_pkg::areg_t [`RN_WIDTH-1:0] rn_src1;
  rename_pkg::areg_t [`RN_WIDTH-1:0] rn_src2;
  logic [`RN_WIDTH-1:0]              rn_out_valid;
  logic                              rn_reject;
  rename_pkg::preg_t [`RN_WIDTH-1:0] rn_pdst;
  rename_pkg::preg_t [`RN_WIDTH-1:0] rn_psrc1;
  rename_pkg::preg_t [`RN_WIDTH-1:0] rn_psrc2;
  rename_pkg::preg_t [`RN_WIDTH-1:0] rn_old_pdst;
  logic [`CM_WIDTH-1:0]              cm_valid;
  rename_pkg::areg_t [`CM_WIDTH-1:0] cm_areg;
  rename_pkg::preg_t [`CM_WIDTH-1:0] cm_preg;
  rename_pkg::preg_t [`CM_WIDTH-1:0] cm_old_preg;
  logic [`PREG_NUM-1:0]              arch_valid;
  rename_pkg::fcnt_t                 free_cnt;

  rename_top u_rename_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .rn_valid_i     (rn_valid),
    .rn_dst_en_i    (rn_dst_en),
    .rn_dst_i       (rn_dst),
    .rn_src1_i      (rn_src1),
    .rn_src2_i      (rn_src2),
    .rn_out_valid_o (rn_out_valid),
    .rn_reject_o    (rn_reject),
    .rn_pdst_o      (rn_pdst),
    .rn_psrc1_o     (rn_psrc1),
    .rn_psrc2_o     (rn_psrc2),
    .rn_old_pdst_o  (rn_old_pdst),
    .cm_valid_i     (cm_valid),
    .cm_areg_i      (cm_areg),
    .cm_preg_i      (cm_preg),
    .cm_old_preg_i  (cm_old_preg),
    .arch_valid_o   (arch_valid),
    .free_cnt_o     (free_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  // ============================================================
  // Reference model state
  // ============================================================

  rename_pkg::preg_t map_m [`AREG_NUM];  // Speculative map
  rename_pkg::preg_t free_m [$];         // Free regs, head at index 0
  wide_t             bitmap_m;           // Committed-state bits
  wide_t             busy_m;             // Regs mapped or in flight
  rename_pkg::areg_t cq_areg [$];        // In-order commit queue
  rename_pkg::preg_t cq_pdst [$];
  rename_pkg::preg_t cq_old [$];

  // Expected response of the previous request
  logic [`RN_WIDTH-1:0]              pend_valid;
  logic                              pend_reject;
  logic [`RN_WIDTH-1:0]              pend_chk_lk;   // Lookups predictable
  logic [`RN_WIDTH-1:0]              pend_chk_dst;  // pdst granted
  rename_pkg::preg_t [`RN_WIDTH-1:0] pend_pdst;
  rename_pkg::preg_t [`RN_WIDTH-1:0] pend_psrc1;
  rename_pkg::preg_t [`RN_WIDTH-1:0] pend_psrc2;
  rename_pkg::preg_t [`RN_WIDTH-1:0] pend_old;

  logic [31:0] rng_state;
  int          err_cnt;     // Value mismatches
  int          fail_cnt;    // Timeouts and other failures
  int          reject_cnt;
  int          bypass_cnt;

  // LCG, upper bits are the better ones
  function automatic int unsigned next_rand(input int unsigned range);
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return (rng_state >> 16) % range;
  endfunction

  task automatic check_val(input string name, input wide_t exp, input wide_t act);
    assert (exp === act) else begin
      $display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
      err_cnt++;
    end
  endtask

  // ============================================================
  // One clock cycle: drive, check, advance model
  // ============================================================

  task automatic run_cycle(input int unsigned rn_max, input int unsigned cm_pct);
    logic [`RN_WIDTH-1:0]              v;
    logic [`RN_WIDTH-1:0]              de;
    rename_pkg::areg_t [`RN_WIDTH-1:0] d;
    rename_pkg::areg_t [`RN_WIDTH-1:0] s1;
    rename_pkg::areg_t [`RN_WIDTH-1:0] s2;
    rename_pkg::preg_t [`RN_WIDTH-1:0] np;
    rename_pkg::preg_t [`RN_WIDTH-1:0] e1;
    rename_pkg::preg_t [`RN_WIDTH-1:0] e2;
    rename_pkg::preg_t [`RN_WIDTH-1:0] eo;
    logic [`RN_WIDTH-1:0]              chk_lk;
    logic [`CM_WIDTH-1:0]              cv;
    rename_pkg::areg_t [`CM_WIDTH-1:0] ca;
    rename_pkg::preg_t [`CM_WIDTH-1:0] cp;
    rename_pkg::preg_t [`CM_WIDTH-1:0] co;
    int                                n_rn;
    int                                demand;
    int                                cnt_before;
    int                                di;
    logic                              rej;
    logic                              byp;
    wide_t                             bm_exp;

    @(posedge clk);
    cnt_before = free_m.size();  // What free_cnt_o holds now
    n_rn   = next_rand(rn_max + 1);
    v      = '0;
    de     = '0;
    d      = '0;
    s1     = '0;
    s2     = '0;
    demand = 0;
    for (int k = 0; k < `RN_WIDTH; k++) begin
      if (k < n_rn) begin  // Packed from slot 0
        v[k]  = 1'b1;
        de[k] = (next_rand(4) != 0);
        d[k]  = rename_pkg::areg_t'(next_rand(`AREG_NUM));
        s1[k] = rename_pkg::areg_t'(next_rand(`AREG_NUM));
        s2[k] = rename_pkg::areg_t'(next_rand(`AREG_NUM));
        if (k > 0 && next_rand(4) == 0) s1[k] = d[k-1];  // Provoke bypass
        if (k > 0 && next_rand(6) == 0) d[k] = d[k-1];   // Same dst twice
        if (de[k]) demand++;
      end
    end
    rej = (demand > cnt_before);

    // New regs in dst-slot order from the model FIFO
    di = 0;
    np = '0;
    for (int k = 0; k < `RN_WIDTH; k++) begin
      if (v[k] && de[k]) begin
        if (!rej) np[k] = free_m[di];
        di++;
      end
    end

    // Map lookups, older slots in the group take priority over the map
    for (int k = 0; k < `RN_WIDTH; k++) begin
      e1[k]     = map_m[s1[k]];
      e2[k]     = map_m[s2[k]];
      eo[k]     = map_m[d[k]];
      chk_lk[k] = 1'b1;
      byp       = 1'b0;
      for (int j = 0; j < k; j++) begin
        if (v[j] && de[j]) begin
          if (d[j] == s1[k]) begin
            e1[k] = np[j];
            byp   = 1'b1;
          end
          if (d[j] == s2[k]) begin
            e2[k] = np[j];
            byp   = 1'b1;
          end
          if (d[j] == d[k]) begin
            eo[k] = np[j];
            byp   = 1'b1;
          end
        end
      end
      if (byp && rej) chk_lk[k] = 1'b0;  // Head regs not meaningful on reject
      if (byp && !rej && v[k]) bypass_cnt++;
    end

    // Commit the oldest queued entries, in order
    cv = '0;
    ca = '0;
    cp = '0;
    co = '0;
    for (int c = 0; c < `CM_WIDTH; c++) begin
      if (c < cq_pdst.size() && (c == 0 || cv[c-1]) && next_rand(100) < cm_pct) begin
        cv[c] = 1'b1;
        ca[c] = cq_areg[c];
        cp[c] = cq_pdst[c];
        co[c] = cq_old[c];
      end
    end
    bm_exp = bitmap_m;
    for (int c = 0; c < `CM_WIDTH; c++) begin
      if (cv[c]) begin
        bm_exp[cp[c]] = 1'b1;
        bm_exp[co[c]] = 1'b0;
      end
    end

    rn_valid    <= v;
    rn_dst_en   <= de;
    rn_dst      <= d;
    rn_src1     <= s1;
    rn_src2     <= s2;
    cm_valid    <= cv;
    cm_areg     <= ca;
    cm_preg     <= cp;
    cm_old_preg <= co;

    @(negedge clk);
    check_val("free_count", wide_t'(cnt_before), wide_t'(free_cnt));
    check_val("commit_bitmap", bm_exp, arch_valid);  // Same-cycle view
    check_val("rename_valid", wide_t'(pend_valid), wide_t'(rn_out_valid));
    check_val("rename_reject", wide_t'(pend_reject), wide_t'(rn_reject));
    for (int k = 0; k < `RN_WIDTH; k++) begin
      if (pend_valid[k] && pend_chk_lk[k]) begin
        check_val($sformatf("rename_map psrc1[%0d]", k), wide_t'(pend_psrc1[k]),
                  wide_t'(rn_psrc1[k]));
        check_val($sformatf("rename_map psrc2[%0d]", k), wide_t'(pend_psrc2[k]),
                  wide_t'(rn_psrc2[k]));
        check_val($sformatf("rename_map old_pdst[%0d]", k), wide_t'(pend_old[k]),
                  wide_t'(rn_old_pdst[k]));
      end
      if (pend_valid[k] && pend_chk_dst[k]) begin
        check_val($sformatf("recycle pdst[%0d]", k), wide_t'(pend_pdst[k]),
                  wide_t'(rn_pdst[k]));
        // DUT reg must not be mapped or in flight already
        assert (!busy_m[rn_pdst[k]]) else begin
          $display("Physical register %0d was handed out while still in use", rn_pdst[k]);
          fail_cnt++;
        end
        busy_m[rn_pdst[k]] = 1'b1;  // In use until its successor commits
      end
    end

    // Advance model, allocations before releases
    if (!rej) begin
      for (int k = 0; k < `RN_WIDTH; k++) begin
        if (v[k] && de[k]) begin
          void'(free_m.pop_front());
          map_m[d[k]] = np[k];  // Later slot wins
          cq_areg.push_back(d[k]);
          cq_pdst.push_back(np[k]);
          cq_old.push_back(eo[k]);
        end
      end
    end else begin
      reject_cnt++;
    end
    for (int c = 0; c < `CM_WIDTH; c++) begin
      if (cv[c]) begin
        void'(cq_areg.pop_front());
        void'(cq_pdst.pop_front());
        void'(cq_old.pop_front());
        free_m.push_back(co[c]);  // Allocatable next cycle
        busy_m[co[c]] = 1'b0;
      end
    end
    bitmap_m = bm_exp;

    pend_valid   = v;
    pend_reject  = rej;
    pend_chk_lk  = chk_lk;
    pend_chk_dst = rej ? '0 : (v & de);
    pend_pdst    = np;
    pend_psrc1   = e1;
    pend_psrc2   = e2;
    pend_old     = eo;
  endtask

  // ============================================================
  // Main sequence
  // ============================================================

  initial begin
    wide_t reset_bits;
    int    t;

    rst_n       = 1'b0;
    rn_valid    = '0;
    rn_dst_en   = '0;
    rn_dst      = '0;
    rn_src1     = '0;
    rn_src2     = '0;
    cm_valid    = '0;
    cm_areg     = '0;
    cm_preg     = '0;
    cm_old_preg = '0;
    rng_state   = SEED;
    err_cnt     = 0;
    fail_cnt    = 0;
    reject_cnt  = 0;
    bypass_cnt  = 0;

    for (int i = 0; i < `AREG_NUM; i++) map_m[i] = rename_pkg::preg_t'(i);  // Identity
    for (int i = `AREG_NUM; i < `PREG_NUM; i++) free_m.push_back(rename_pkg::preg_t'(i));
    bitmap_m                 = '0;
    bitmap_m[`AREG_NUM-1:0]  = '1;
    busy_m                   = bitmap_m;
    reset_bits               = bitmap_m;
    pend_valid               = '0;
    pend_reject              = 1'b0;
    pend_chk_lk              = '0;
    pend_chk_dst             = '0;

    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    // Reset state
    @(negedge clk);
    t = 0;
    while (free_cnt !== rename_pkg::fcnt_t'(`PREG_NUM - `AREG_NUM) && t < WAIT_LIMIT) begin
      @(negedge clk);
      t++;
    end
    if (t == WAIT_LIMIT) begin
      $display("Timeout: free count never reached its reset value");
      fail_cnt++;
    end
    check_val("reset free_cnt", wide_t'(`PREG_NUM - `AREG_NUM), wide_t'(free_cnt));
    check_val("reset arch_valid", reset_bits, arch_valid);

    // Alternate balanced traffic with commit-starved phases that drain the list
    for (int i = 0; i < NUM_ITER; i++) begin
      if ((i / 150) % 2 == 1) run_cycle(`RN_WIDTH, 15);
      else run_cycle(`RN_WIDTH, 70);
    end

    // Retire everything still in flight
    t = 0;
    while (cq_pdst.size() != 0 && t < WAIT_LIMIT) begin
      run_cycle(0, 100);
      t++;
    end
    if (cq_pdst.size() != 0) begin
      $display("Timeout: commit queue did not drain");
      fail_cnt++;
    end
    t = 0;
    run_cycle(0, 0);
    while (free_cnt !== rename_pkg::fcnt_t'(`PREG_NUM - `AREG_NUM) && t < WAIT_LIMIT) begin
      run_cycle(0, 0);
      t++;
    end
    if (t == WAIT_LIMIT) begin
      $display("Timeout: free list did not refill after the final commits");
      fail_cnt++;
    end

    if (reject_cnt == 0) begin
      $display("No rename group was ever rejected");
      fail_cnt++;
    end
    if (bypass_cnt == 0) begin
      $display("No intra-group bypass was ever exercised");
      fail_cnt++;
    end

    $display("Errors: %0d value mismatches, %0d other failures (%0d rejects, %0d bypasses)",
             err_cnt, fail_cnt, reject_cnt, bypass_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* rename_top.sv */
// Rename subsystem top; no back-pressure, commits must come in order from a correct ROB
`timescale 1ns/1ps
`include "rename_defs.svh"

module rename_top (
  input  logic                                  clk,
  input  logic                                  rst_n,
  // ============================================================
  // Rename request
  // ============================================================
  input  logic [`RN_WIDTH-1:0]                  rn_valid_i,
  input  logic [`RN_WIDTH-1:0]                  rn_dst_en_i,
  input  rename_pkg::areg_t [`RN_WIDTH-1:0]     rn_dst_i,
  input  rename_pkg::areg_t [`RN_WIDTH-1:0]     rn_src1_i,
  input  rename_pkg::areg_t [`RN_WIDTH-1:0]     rn_src2_i,
  // ============================================================
  // Rename result, one cycle later
  // ============================================================
  output logic [`RN_WIDTH-1:0]                  rn_out_valid_o,
  output logic                                  rn_reject_o,
  output rename_pkg::preg_t [`RN_WIDTH-1:0]     rn_pdst_o,
  output rename_pkg::preg_t [`RN_WIDTH-1:0]     rn_psrc1_o,
  output rename_pkg::preg_t [`RN_WIDTH-1:0]     rn_psrc2_o,
  output rename_pkg::preg_t [`RN_WIDTH-1:0]     rn_old_pdst_o,
  // ============================================================
  // Commit
  // ============================================================
  input  logic [`CM_WIDTH-1:0]                  cm_valid_i,
  input  rename_pkg::areg_t [`CM_WIDTH-1:0]     cm_areg_i,      // ROB side only, bitmap ignores it
  input  rename_pkg::preg_t [`CM_WIDTH-1:0]     cm_preg_i,
  input  rename_pkg::preg_t [`CM_WIDTH-1:0]     cm_old_preg_i,
  output logic [`PREG_NUM-1:0]                  arch_valid_o,   // Combinational
  output rename_pkg::fcnt_t                     free_cnt_o      // Registered
);

  logic                                alloc_ok;  // Group fits in free list
  rename_pkg::preg_t [`RN_WIDTH-1:0]   fl_preg;   // Head regs per slot

  // Old regs of commits go straight back as releases
  free_list u_free_list (
    .clk          (clk),
    .rst_n        (rst_n),
    .rn_valid_i   (rn_valid_i),
    .rn_dst_en_i  (rn_dst_en_i),
    .rel_valid_i  (cm_valid_i),
    .rel_preg_i   (cm_old_preg_i),
    .alloc_ok_o   (alloc_ok),
    .alloc_preg_o (fl_preg),
    .free_cnt_o   (free_cnt_o)
  );

  spec_alias_table u_spec_alias_table (
    .clk            (clk),
    .rst_n          (rst_n),
    .rn_valid_i     (rn_valid_i),
    .rn_dst_en_i    (rn_dst_en_i),
    .rn_dst_i       (rn_dst_i),
    .rn_src1_i      (rn_src1_i),
    .rn_src2_i      (rn_src2_i),
    .alloc_ok_i     (alloc_ok),
    .alloc_preg_i   (fl_preg),
    .rn_out_valid_o (rn_out_valid_o),
    .rn_reject_o    (rn_reject_o),
    .rn_pdst_o      (rn_pdst_o),
    .rn_psrc1_o     (rn_psrc1_o),
    .rn_psrc2_o     (rn_psrc2_o),
    .rn_old_pdst_o  (rn_old_pdst_o)
  );

  arch_alias_table u_arch_alias_table (
    .clk           (clk),
    .rst_n         (rst_n),
    .cm_valid_i    (cm_valid_i),
    .cm_preg_i     (cm_preg_i),
    .cm_old_preg_i (cm_old_preg_i),
    .arch_valid_o  (arch_valid_o)
  );

endmodule

/* arch_alias_table.sv */
// Committed-state bitmap; output is combinational and includes this cycle's commits
`timescale 1ns/1ps
`include "rename_defs.svh"

module arch_alias_table (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [`CM_WIDTH-1:0]                  cm_valid_i,     // Per commit slot
  input  rename_pkg::preg_t [`CM_WIDTH-1:0]     cm_preg_i,      // New reg, now committed
  input  rename_pkg::preg_t [`CM_WIDTH-1:0]     cm_old_preg_i,  // Replaced reg
  output logic [`PREG_NUM-1:0]                  arch_valid_o
);

  // ============================================================
  // Bitmap state
  // ============================================================

  logic [`PREG_NUM-1:0] valid_q;  // One bit per preg
  logic [`PREG_NUM-1:0] valid_n;

  // Apply commits in slot order
  always_comb begin
    valid_n = valid_q;
    for (int c = 0; c < `CM_WIDTH; c++) begin
      if (cm_valid_i[c]) begin
        valid_n[cm_preg_i[c]]     = 1'b1;
        valid_n[cm_old_preg_i[c]] = 1'b0;  // Old reg freed
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      valid_q[`AREG_NUM-1:0] <= '1;  // Identity map at reset
    end else begin
      valid_q <= valid_n;
    end
  end

  assign arch_valid_o = valid_n;  // Next state, same cycle view

endmodule

/* spec_alias_table.sv */
// Speculative rename map; no flush recovery, rejected group leaves the map untouched
`timescale 1ns/1ps
`include "rename_defs.svh"

module spec_alias_table (
  input  logic                                  clk,
  input  logic                                  rst_n,
  // Rename request, valid slots packed from slot 0
  input  logic [`RN_WIDTH-1:0]                  rn_valid_i,
  input  logic [`RN_WIDTH-1:0]                  rn_dst_en_i,
  input  rename_pkg::areg_t [`RN_WIDTH-1:0]     rn_dst_i,
  input  rename_pkg::areg_t [`RN_WIDTH-1:0]     rn_src1_i,
  input  rename_pkg::areg_t [`RN_WIDTH-1:0]     rn_src2_i,
  // From the free list
  input  logic                                  alloc_ok_i,
  input  rename_pkg::preg_t [`RN_WIDTH-1:0]     alloc_preg_i,
  // Result, one cycle after request
  output logic [`RN_WIDTH-1:0]                  rn_out_valid_o,
  output logic                                  rn_reject_o,
  output rename_pkg::preg_t [`RN_WIDTH-1:0]     rn_pdst_o,
  output rename_pkg::preg_t [`RN_WIDTH-1:0]     rn_psrc1_o,
  output rename_pkg::preg_t [`RN_WIDTH-1:0]     rn_psrc2_o,
  output rename_pkg::preg_t [`RN_WIDTH-1:0]     rn_old_pdst_o
);

  // ============================================================
  // Map storage
  // ============================================================

  rename_pkg::preg_t map_q [`AREG_NUM];  // areg -> newest preg

  rename_pkg::preg_t [`RN_WIDTH-1:0] psrc1;     // Looked up, bypassed
  rename_pkg::preg_t [`RN_WIDTH-1:0] psrc2;
  rename_pkg::preg_t [`RN_WIDTH-1:0] old_pdst;
  logic              [`RN_WIDTH-1:0] wr_en;     // Slot writes a dst

  assign wr_en = rn_valid_i & rn_dst_en_i;

  // ============================================================
  // Lookup with intra-group bypass
  // ============================================================

  always_comb begin
    for (int k = 0; k < `RN_WIDTH; k++) begin
      psrc1[k]    = map_q[rn_src1_i[k]];
      psrc2[k]    = map_q[rn_src2_i[k]];
      old_pdst[k] = map_q[rn_dst_i[k]];
      // Older slots in the group override the map, youngest older slot last
      for (int j = 0; j < k; j++) begin
        if (wr_en[j] && (rn_dst_i[j] == rn_src1_i[k])) begin
          psrc1[k] = alloc_preg_i[j];
        end
        if (wr_en[j] && (rn_dst_i[j] == rn_src2_i[k])) begin
          psrc2[k] = alloc_preg_i[j];
        end
        if (wr_en[j] && (rn_dst_i[j] == rn_dst_i[k])) begin
          old_pdst[k] = alloc_preg_i[j];  // Overwrites what slot j just made
        end
      end
    end
  end

  // ============================================================
  // Map update on grant
  // ============================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `AREG_NUM; i++) begin
        map_q[i] <= rename_pkg::preg_t'(i);  // Identity map
      end
    end else if (alloc_ok_i) begin
      for (int k = 0; k < `RN_WIDTH; k++) begin
        if (wr_en[k]) begin
          map_q[rn_dst_i[k]] <= alloc_preg_i[k];  // Later slot wins on same areg
        end
      end
    end
  end

  // ============================================================
  // Result registers
  // ============================================================

  // Control strobes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rn_out_valid_o <= '0;
      rn_reject_o    <= 1'b0;
    end else begin
      rn_out_valid_o <= rn_valid_i;
      rn_reject_o    <= ~alloc_ok_i;  // High only when demand exceeds count
    end
  end

  // Payload, follows the strobes
  always_ff @(posedge clk) begin
    rn_pdst_o     <= alloc_preg_i;
    rn_psrc1_o    <= psrc1;
    rn_psrc2_o    <= psrc2;
    rn_old_pdst_o <= old_pdst;
  end

endmodule

/* free_list.sv */
// Free physical register queue; caller must never release more regs than the queue can hold
`timescale 1ns/1ps
`include "rename_defs.svh"

module free_list (
  input  logic                                  clk,
  input  logic                                  rst_n,
  // Rename side
  input  logic [`RN_WIDTH-1:0]                  rn_valid_i,
  input  logic [`RN_WIDTH-1:0]                  rn_dst_en_i,
  // Commit side, old regs coming back
  input  logic [`CM_WIDTH-1:0]                  rel_valid_i,
  input  rename_pkg::preg_t [`CM_WIDTH-1:0]     rel_preg_i,
  // Grant and head regs
  output logic                                  alloc_ok_o,
  output rename_pkg::preg_t [`RN_WIDTH-1:0]     alloc_preg_o,
  output rename_pkg::fcnt_t                     free_cnt_o
);

  // ============================================================
  // Queue storage and pointers
  // ============================================================

  rename_pkg::preg_t fifo_q [`PREG_NUM];  // Circular array of free regs
  rename_pkg::preg_t head_q;              // Next reg to hand out
  rename_pkg::preg_t tail_q;              // Next slot to refill
  rename_pkg::fcnt_t cnt_q;               // Free regs held

  rename_pkg::fcnt_t demand;              // Dst slots in this group
  rename_pkg::fcnt_t rel_cnt;             // Releases this cycle
  rename_pkg::fcnt_t grant_cnt;           // Demand actually taken
  rename_pkg::preg_t rel_ofs [`CM_WIDTH]; // Tail offset per release slot

  // ============================================================
  // Demand, grant and head lookup
  // ============================================================

  always_comb begin
    rename_pkg::preg_t dst_ofs;
    dst_ofs = '0;
    demand  = '0;
    for (int k = 0; k < `RN_WIDTH; k++) begin
      // Packed over dst slots only
      alloc_preg_o[k] = fifo_q[head_q + dst_ofs];
      if (rn_valid_i[k] && rn_dst_en_i[k]) begin
        dst_ofs = dst_ofs + 1'b1;
        demand  = demand + 1'b1;
      end
    end
  end

  assign alloc_ok_o = (demand <= cnt_q);     // Whole group or nothing
  assign grant_cnt  = alloc_ok_o ? demand : '0;

  // Tail offsets for releases, slot order
  always_comb begin
    rel_cnt = '0;
    for (int c = 0; c < `CM_WIDTH; c++) begin
      rel_ofs[c] = rel_cnt[$clog2(`PREG_NUM)-1:0];
      if (rel_valid_i[c]) begin
        rel_cnt = rel_cnt + 1'b1;
      end
    end
  end

  // ============================================================
  // State update
  // ============================================================

  // Pointers and count
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_q <= '0;
      tail_q <= rename_pkg::preg_t'(`PREG_NUM - `AREG_NUM);  // Past the initial free regs
      cnt_q  <= rename_pkg::fcnt_t'(`PREG_NUM - `AREG_NUM);
    end else begin
      head_q <= head_q + grant_cnt[$clog2(`PREG_NUM)-1:0];  // Wraps, power of two
      tail_q <= tail_q + rel_cnt[$clog2(`PREG_NUM)-1:0];
      cnt_q  <= cnt_q + rel_cnt - grant_cnt;
    end
  end

  // Queue contents; initial image is AREG_NUM upward
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `PREG_NUM; i++) begin
        // Entries past the tail wrap around, never read before refill
        fifo_q[i] <= rename_pkg::preg_t'(i + `AREG_NUM);
      end
    end else begin
      for (int c = 0; c < `CM_WIDTH; c++) begin
        if (rel_valid_i[c]) begin
          fifo_q[tail_q + rel_ofs[c]] <= rel_preg_i[c];  // Visible to alloc next cycle
        end
      end
    end
  end

  assign free_cnt_o = cnt_q;  // Registered count

endmodule

/* rename_pkg.sv */
// Rename index types; widths follow the macros in the shared defs header
`include "rename_defs.svh"

package rename_pkg;

  // ============================================================
  // Register index types
  // ============================================================

  // Architectural register index
  typedef logic [$clog2(`AREG_NUM)-1:0] areg_t;

  // Physical register index
  typedef logic [$clog2(`PREG_NUM)-1:0] preg_t;

  // Free list occupancy, one bit wider so a full list fits
  typedef logic [$clog2(`PREG_NUM):0] fcnt_t;

endpackage

/* rename_defs.svh */
// Rename widths; PREG_NUM must be a power of two larger than AREG_NUM
`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

// ============================================================
// Pipeline widths
// ============================================================

// Instructions renamed per cycle
`define RN_WIDTH 2

// Instructions committed per cycle
`define CM_WIDTH 2

// ============================================================
// Register file sizes
// ============================================================

`define AREG_NUM 32  // Architectural registers

// Physical registers, power of two
`define PREG_NUM 64

`endif
